// File: rtl/axi_pkg.sv
package axi_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 64;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // full-width beats only
    localparam logic [2:0] AXI_SIZE_FULL = 3'($clog2(AXI_STRB_W));
    localparam logic [3:0] AXI_CACHE_MOD = 4'b0011;  // normal, bufferable
    localparam logic [2:0] AXI_PROT_DATA = 3'b000;   // unprivileged secure data

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        axi_burst_e            burst;
        logic [3:0]            cache;
        logic [2:0]            prot;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;  // same field set on both address channels

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        axi_resp_e             resp;
        logic                  last;
    } axi_r_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        axi_resp_e           resp;
    } axi_b_t;

    // slave and decode errors both count as a failed access
    function automatic logic resp_err(axi_resp_e resp);
        return (resp == SLVERR) || (resp == DECERR);
    endfunction

endpackage

// File: rtl/dcache_pkg.sv
package dcache_pkg;

    localparam int LINE_BEATS = 4;
    localparam int LINE_BYTES = 32;
    localparam int LINE_OFFS_W = $clog2(LINE_BYTES);
    localparam int BEAT_IDX_W = $clog2(LINE_BEATS);

    localparam logic [7:0] LINE_AXI_LEN = 8'(LINE_BEATS - 1);  // awlen/arlen of one line

    typedef logic [LINE_BYTES*8-1:0] line_data_t;
    typedef logic [LINE_BYTES-1:0]   line_strb_t;

    typedef struct packed {
        logic [axi_pkg::AXI_ADDR_W-1:0] addr;
    } refill_req_t;

    typedef struct packed {
        logic [axi_pkg::AXI_DATA_W-1:0] data;
        logic [BEAT_IDX_W-1:0]          idx;   // beat position in the line
        logic                           last;
        logic                           err;
    } refill_beat_t;

    typedef struct packed {
        logic [axi_pkg::AXI_ADDR_W-1:0] addr;
        line_data_t                     data;
        line_strb_t                     strb;  // one bit per line byte
    } wb_req_t;

    typedef struct packed {
        logic err;
    } wb_rsp_t;

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

endpackage

// File: rtl/dcache_line_reader.sv
`timescale 1ns/1ps

module dcache_line_reader #(
    parameter logic [axi_pkg::AXI_ID_W-1:0] TXN_ID = 1
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     refill_valid_i,
    input  dcache_pkg::refill_req_t  refill_req_i,
    output logic                     refill_ready_o,
    output logic                     refill_beat_valid_o,
    output dcache_pkg::refill_beat_t refill_beat_o,
    output logic                     axi_ar_valid_o,
    input  logic                     axi_ar_ready_i,
    output axi_pkg::axi_ar_t         axi_ar_o,
    input  logic                     axi_r_valid_i,
    output logic                     axi_r_ready_o,
    input  axi_pkg::axi_r_t          axi_r_i
);
    import axi_pkg::*;
    import dcache_pkg::*;

    rd_state_e             state_q;
    rd_state_e             state_d;
    logic [AXI_ADDR_W-1:0] addr_q;
    logic [BEAT_IDX_W-1:0] beat_cnt_q;
    logic                  beat_valid_q;
    refill_beat_t          beat_q;
    logic                  req_take;
    logic                  ar_hs;
    logic                  r_hs;

    assign req_take = (state_q == RD_IDLE) && refill_valid_i;
    assign ar_hs    = axi_ar_valid_o && axi_ar_ready_i;
    assign r_hs     = axi_r_valid_i && axi_r_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (refill_valid_i) begin
                    state_d = RD_ADDR;
                end
            end
            RD_ADDR: begin
                if (ar_hs) begin
                    state_d = RD_DATA;
                end
            end
            RD_DATA: begin
                if (r_hs && axi_r_i.last) begin
                    state_d = RD_IDLE;  // ready again with the last beat out
                end
            end
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q      <= RD_IDLE;
            beat_cnt_q   <= '0;
            beat_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            beat_valid_q <= r_hs;
            if (req_take) begin
                beat_cnt_q <= '0;
            end else if (r_hs) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // line address and returned beat
    always_ff @(posedge clock) begin
        if (req_take) begin
            addr_q <= {refill_req_i.addr[AXI_ADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};
        end
        if (r_hs) begin
            beat_q.data <= axi_r_i.data;
            beat_q.idx  <= beat_cnt_q;
            beat_q.last <= axi_r_i.last;
            beat_q.err  <= resp_err(axi_r_i.resp);
        end
    end

    assign refill_ready_o      = (state_q == RD_IDLE);
    assign refill_beat_valid_o = beat_valid_q;
    assign refill_beat_o       = beat_q;
    assign axi_ar_valid_o      = (state_q == RD_ADDR);
    assign axi_r_ready_o       = (state_q == RD_DATA);

    always_comb begin
        axi_ar_o.id    = TXN_ID;
        axi_ar_o.addr  = addr_q;
        axi_ar_o.len   = LINE_AXI_LEN;  // four beats
        axi_ar_o.size  = AXI_SIZE_FULL;
        axi_ar_o.burst = INCR;
        axi_ar_o.cache = AXI_CACHE_MOD;
        axi_ar_o.prot  = AXI_PROT_DATA;
    end

endmodule

// File: rtl/dcache_line_writer.sv
`timescale 1ns/1ps

module dcache_line_writer #(
    parameter logic [axi_pkg::AXI_ID_W-1:0] TXN_ID = 1
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                wb_valid_i,
    input  dcache_pkg::wb_req_t wb_req_i,
    output logic                wb_ready_o,
    output logic                wb_done_o,
    output dcache_pkg::wb_rsp_t wb_rsp_o,
    output logic                axi_aw_valid_o,
    input  logic                axi_aw_ready_i,
    output axi_pkg::axi_aw_t    axi_aw_o,
    output logic                axi_w_valid_o,
    input  logic                axi_w_ready_i,
    output axi_pkg::axi_w_t     axi_w_o,
    input  logic                axi_b_valid_i,
    output logic                axi_b_ready_o,
    input  axi_pkg::axi_b_t     axi_b_i
);
    import axi_pkg::*;
    import dcache_pkg::*;

    localparam logic [BEAT_IDX_W-1:0] LAST_BEAT = BEAT_IDX_W'(LINE_BEATS - 1);

    wr_state_e             state_q;
    wr_state_e             state_d;
    wb_req_t               req_q;
    wb_rsp_t               rsp_q;
    logic [BEAT_IDX_W-1:0] beat_cnt_q;
    logic                  done_q;
    logic                  req_take;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  b_hs;
    logic                  w_last;

    assign req_take = (state_q == WR_IDLE) && wb_valid_i;
    assign aw_hs    = axi_aw_valid_o && axi_aw_ready_i;
    assign w_hs     = axi_w_valid_o && axi_w_ready_i;
    assign b_hs     = axi_b_valid_i && axi_b_ready_o;
    assign w_last   = (beat_cnt_q == LAST_BEAT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: begin
                if (wb_valid_i) begin
                    state_d = WR_ADDR;
                end
            end
            WR_ADDR: begin
                if (aw_hs) begin
                    state_d = WR_DATA;
                end
            end
            WR_DATA: begin
                if (w_hs && w_last) begin
                    state_d = WR_RESP;
                end
            end
            WR_RESP: begin
                if (b_hs) begin
                    state_d = WR_IDLE;
                end
            end
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q    <= WR_IDLE;
            beat_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= b_hs;  // one-cycle completion strobe
            if (req_take) begin
                beat_cnt_q <= '0;
            end else if (w_hs) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // whole line held until the burst is done
    always_ff @(posedge clock) begin
        if (req_take) begin
            req_q.addr <= {wb_req_i.addr[AXI_ADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};
            req_q.data <= wb_req_i.data;
            req_q.strb <= wb_req_i.strb;
        end
        if (b_hs) begin
            rsp_q.err <= resp_err(axi_b_i.resp);
        end
    end

    assign wb_ready_o     = (state_q == WR_IDLE);
    assign wb_done_o      = done_q;
    assign wb_rsp_o       = rsp_q;
    assign axi_aw_valid_o = (state_q == WR_ADDR);
    assign axi_w_valid_o  = (state_q == WR_DATA);
    assign axi_b_ready_o  = (state_q == WR_RESP);

    always_comb begin
        axi_aw_o.id    = TXN_ID;
        axi_aw_o.addr  = req_q.addr;
        axi_aw_o.len   = LINE_AXI_LEN;
        axi_aw_o.size  = AXI_SIZE_FULL;
        axi_aw_o.burst = INCR;
        axi_aw_o.cache = AXI_CACHE_MOD;
        axi_aw_o.prot  = AXI_PROT_DATA;
    end

    // beat k takes line bytes 8k..8k+7 and their mask bits
    always_comb begin
        axi_w_o.data = req_q.data[beat_cnt_q*AXI_DATA_W +: AXI_DATA_W];
        axi_w_o.strb = req_q.strb[beat_cnt_q*AXI_STRB_W +: AXI_STRB_W];
        axi_w_o.last = w_last;
    end

endmodule

// File: rtl/dcache_axi_bridge.sv
`timescale 1ns/1ps

module dcache_axi_bridge #(
    parameter logic [axi_pkg::AXI_ID_W-1:0] TXN_ID = 1
) (
    input  logic                     clock,
    input  logic                     reset,
    // refill side
    input  logic                     refill_valid_i,
    input  dcache_pkg::refill_req_t  refill_req_i,
    output logic                     refill_ready_o,
    output logic                     refill_beat_valid_o,
    output dcache_pkg::refill_beat_t refill_beat_o,
    // writeback side
    input  logic                     wb_valid_i,
    input  dcache_pkg::wb_req_t      wb_req_i,
    output logic                     wb_ready_o,
    output logic                     wb_done_o,
    output dcache_pkg::wb_rsp_t      wb_rsp_o,
    // AXI4 master
    output logic                     axi_ar_valid_o,
    input  logic                     axi_ar_ready_i,
    output axi_pkg::axi_ar_t         axi_ar_o,
    input  logic                     axi_r_valid_i,
    output logic                     axi_r_ready_o,
    input  axi_pkg::axi_r_t          axi_r_i,
    output logic                     axi_aw_valid_o,
    input  logic                     axi_aw_ready_i,
    output axi_pkg::axi_aw_t         axi_aw_o,
    output logic                     axi_w_valid_o,
    input  logic                     axi_w_ready_i,
    output axi_pkg::axi_w_t          axi_w_o,
    input  logic                     axi_b_valid_i,
    output logic                     axi_b_ready_o,
    input  axi_pkg::axi_b_t          axi_b_i
);

    // read and write paths run independently
    dcache_line_reader #(
        .TXN_ID (TXN_ID)
    ) u_reader (
        .clock               (clock),
        .reset               (reset),
        .refill_valid_i      (refill_valid_i),
        .refill_req_i        (refill_req_i),
        .refill_ready_o      (refill_ready_o),
        .refill_beat_valid_o (refill_beat_valid_o),
        .refill_beat_o       (refill_beat_o),
        .axi_ar_valid_o      (axi_ar_valid_o),
        .axi_ar_ready_i      (axi_ar_ready_i),
        .axi_ar_o            (axi_ar_o),
        .axi_r_valid_i       (axi_r_valid_i),
        .axi_r_ready_o       (axi_r_ready_o),
        .axi_r_i             (axi_r_i)
    );

    dcache_line_writer #(
        .TXN_ID (TXN_ID)
    ) u_writer (
        .clock          (clock),
        .reset          (reset),
        .wb_valid_i     (wb_valid_i),
        .wb_req_i       (wb_req_i),
        .wb_ready_o     (wb_ready_o),
        .wb_done_o      (wb_done_o),
        .wb_rsp_o       (wb_rsp_o),
        .axi_aw_valid_o (axi_aw_valid_o),
        .axi_aw_ready_i (axi_aw_ready_i),
        .axi_aw_o       (axi_aw_o),
        .axi_w_valid_o  (axi_w_valid_o),
        .axi_w_ready_i  (axi_w_ready_i),
        .axi_w_o        (axi_w_o),
        .axi_b_valid_i  (axi_b_valid_i),
        .axi_b_ready_o  (axi_b_ready_o),
        .axi_b_i        (axi_b_i)
    );

endmodule

// File: tb/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model (
    input  logic             clock,
    input  logic             reset,
    input  logic             ar_valid_i,
    output logic             ar_ready_o,
    input  axi_pkg::axi_ar_t ar_i,
    output logic             r_valid_o,
    input  logic             r_ready_i,
    output axi_pkg::axi_r_t  r_o,
    input  logic             aw_valid_i,
    output logic             aw_ready_o,
    input  axi_pkg::axi_aw_t aw_i,
    input  logic             w_valid_i,
    output logic             w_ready_o,
    input  axi_pkg::axi_w_t  w_i,
    output logic             b_valid_o,
    input  logic             b_ready_i,
    output axi_pkg::axi_b_t  b_o
);
    import axi_pkg::*;

    logic [7:0]            mem [0:8191];  // 8 KB with bit 12 as the error region
    logic                  rd_busy;
    logic [AXI_ADDR_W-1:0] rd_addr;
    logic [7:0]            rd_left;
    logic [AXI_ID_W-1:0]   rd_id;
    logic                  wr_busy;
    logic                  wr_err;
    logic                  b_pend;
    logic [AXI_ADDR_W-1:0] wr_addr;
    logic [AXI_ID_W-1:0]   wr_id;
    logic [1:0]            ar_wait;
    logic [1:0]            r_wait;
    logic [1:0]            aw_wait;
    logic [1:0]            w_wait;
    logic [1:0]            b_wait;

    initial begin
        for (int a = 0; a < 8192; a++) begin
            mem[a] = 8'(a * 7 + 3);
        end
    end

    function automatic logic [AXI_DATA_W-1:0] read_beat(input logic [AXI_ADDR_W-1:0] addr);
        logic [AXI_DATA_W-1:0] data;
        for (int i = 0; i < AXI_STRB_W; i++) begin
            data[8*i +: 8] = mem[{addr[12:3], 3'(i)}];
        end
        return data;
    endfunction

    // read side handles one burst at a time
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_o        <= '0;
            rd_busy    <= 1'b0;
            rd_addr    <= '0;
            rd_left    <= '0;
            rd_id      <= '0;
            ar_wait    <= '0;
            r_wait     <= '0;
        end else begin
            ar_ready_o <= 1'b0;
            if (ar_valid_i && ar_ready_o) begin
                rd_busy <= 1'b1;
                rd_addr <= ar_i.addr;
                rd_left <= ar_i.len;
                rd_id   <= ar_i.id;
                ar_wait <= 2'($urandom);
            end else if (ar_valid_i && !rd_busy) begin
                if (ar_wait == 0) begin
                    ar_ready_o <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1'b1;
                end
            end
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                rd_busy   <= !r_o.last;
                rd_addr   <= rd_addr + 8;
                rd_left   <= rd_left - 1'b1;
                r_wait    <= 2'($urandom);
            end else if (rd_busy && !r_valid_o) begin
                if (r_wait == 0) begin
                    r_valid_o <= 1'b1;
                    r_o.id    <= rd_id;
                    r_o.data  <= read_beat(rd_addr);
                    r_o.resp  <= rd_addr[12] ? SLVERR : OKAY;
                    r_o.last  <= (rd_left == 0);
                end else begin
                    r_wait <= r_wait - 1'b1;
                end
            end
        end
    end

    // write side takes the error flag once from the burst address
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            b_valid_o  <= 1'b0;
            b_o        <= '0;
            wr_busy    <= 1'b0;
            wr_err     <= 1'b0;
            b_pend     <= 1'b0;
            wr_addr    <= '0;
            wr_id      <= '0;
            aw_wait    <= '0;
            w_wait     <= '0;
            b_wait     <= '0;
        end else begin
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            if (aw_valid_i && aw_ready_o) begin
                wr_busy <= 1'b1;
                wr_err  <= aw_i.addr[12];
                wr_addr <= aw_i.addr;
                wr_id   <= aw_i.id;
                aw_wait <= 2'($urandom);
            end else if (aw_valid_i && !wr_busy) begin
                if (aw_wait == 0) begin
                    aw_ready_o <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1'b1;
                end
            end
            if (w_valid_i && w_ready_o) begin
                wr_addr <= wr_addr + 8;
                w_wait  <= 2'($urandom);
                b_pend  <= w_i.last;
            end else if (wr_busy && !b_pend && w_valid_i) begin
                if (w_wait == 0) begin
                    w_ready_o <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1'b1;
                end
            end
            if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
                b_pend    <= 1'b0;
                wr_busy   <= 1'b0;
            end else if (b_pend && !b_valid_o) begin
                if (b_wait == 0) begin
                    b_valid_o <= 1'b1;
                    b_o.id    <= wr_id;
                    b_o.resp  <= wr_err ? SLVERR : OKAY;
                    b_wait    <= 2'($urandom);
                end else begin
                    b_wait <= b_wait - 1'b1;
                end
            end
        end
    end

    always @(posedge clock) begin
        if (w_valid_i && w_ready_o && !wr_err) begin
            for (int i = 0; i < AXI_STRB_W; i++) begin
                if (w_i.strb[i]) begin
                    mem[{wr_addr[12:3], 3'(i)}] <= w_i.data[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: tb/dcache_axi_bridge_properties.sv
`timescale 1ns/1ps

module dcache_axi_bridge_properties (
    input logic                     clock,
    input logic                     reset,
    input logic                     refill_ready_o,
    input logic                     refill_beat_valid_o,
    input dcache_pkg::refill_beat_t refill_beat_o,
    input logic                     axi_ar_valid_o,
    input logic                     axi_ar_ready_i,
    input axi_pkg::axi_ar_t         axi_ar_o,
    input logic                     axi_aw_valid_o,
    input logic                     axi_aw_ready_i,
    input axi_pkg::axi_aw_t         axi_aw_o,
    input logic                     axi_w_valid_o,
    input logic                     axi_w_ready_i,
    input axi_pkg::axi_w_t          axi_w_o
);
    int unsigned fail_count = 0;
    logic [1:0]  w_cnt;  // wraps after the fourth beat

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_cnt <= '0;
        end else if (axi_w_valid_o && axi_w_ready_i) begin
            w_cnt <= w_cnt + 1'b1;
        end
    end

    ar_stable: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_o))
        else begin
            fail_count++;
            $error("AR dropped or changed before its handshake");
        end

    aw_stable: assert property (@(posedge clock) disable iff (!reset)
        axi_aw_valid_o && !axi_aw_ready_i |=> axi_aw_valid_o && $stable(axi_aw_o))
        else begin
            fail_count++;
            $error("AW dropped or changed before its handshake");
        end

    w_stable: assert property (@(posedge clock) disable iff (!reset)
        axi_w_valid_o && !axi_w_ready_i |=> axi_w_valid_o && $stable(axi_w_o))
        else begin
            fail_count++;
            $error("W dropped or changed before its handshake");
        end

    w_framing: assert property (@(posedge clock) disable iff (!reset)
        axi_w_valid_o && axi_w_ready_i |-> (axi_w_o.last == (w_cnt == 2'd3)))
        else begin
            fail_count++;
            $error("W last is not on the fourth beat");
        end

    // only the last beat may coincide with the reader going idle
    beat_when_idle: assert property (@(posedge clock) disable iff (!reset)
        refill_beat_valid_o && refill_ready_o |-> refill_beat_o.last)
        else begin
            fail_count++;
            $error("refill beat output while the reader is idle");
        end

endmodule

bind dcache_axi_bridge dcache_axi_bridge_properties props_i (.*);

// File: tb/dcache_axi_bridge_tb.sv
`timescale 1ns/1ps

module dcache_axi_bridge_tb;
    import axi_pkg::*;
    import dcache_pkg::*;

    localparam logic [AXI_ID_W-1:0] TXN_ID = 4'h5;
    localparam int MAX_TXNS       = 80;
    localparam int CYCLES_PER_TXN = 60;

    logic         clock;
    logic         reset;
    logic         refill_valid_i;
    refill_req_t  refill_req_i;
    logic         refill_ready_o;
    logic         refill_beat_valid_o;
    refill_beat_t refill_beat_o;
    logic         wb_valid_i;
    wb_req_t      wb_req_i;
    logic         wb_ready_o;
    logic         wb_done_o;
    wb_rsp_t      wb_rsp_o;
    logic         axi_ar_valid_o;
    logic         axi_ar_ready_i;
    axi_ar_t      axi_ar_o;
    logic         axi_r_valid_i;
    logic         axi_r_ready_o;
    axi_r_t       axi_r_i;
    logic         axi_aw_valid_o;
    logic         axi_aw_ready_i;
    axi_aw_t      axi_aw_o;
    logic         axi_w_valid_o;
    logic         axi_w_ready_i;
    axi_w_t       axi_w_o;
    logic         axi_b_valid_i;
    logic         axi_b_ready_o;
    axi_b_t       axi_b_i;

    logic [7:0]            shadow [0:8191];  // expected memory contents
    logic [AXI_ADDR_W-1:0] rd_addr_q [$];    // outstanding refill lines, in order
    logic [AXI_ADDR_W-1:0] wb_addr_q [$];    // outstanding writeback lines
    logic [BEAT_IDX_W-1:0] beat_idx = '0;

    dcache_axi_bridge #(
        .TXN_ID (TXN_ID)
    ) dcache_axi_bridge_i (.*);

    axi_slave_model u_slave (
        .clock      (clock),
        .reset      (reset),
        .ar_valid_i (axi_ar_valid_o),
        .ar_ready_o (axi_ar_ready_i),
        .ar_i       (axi_ar_o),
        .r_valid_o  (axi_r_valid_i),
        .r_ready_i  (axi_r_ready_o),
        .r_o        (axi_r_i),
        .aw_valid_i (axi_aw_valid_o),
        .aw_ready_o (axi_aw_ready_i),
        .aw_i       (axi_aw_o),
        .w_valid_i  (axi_w_valid_o),
        .w_ready_o  (axi_w_ready_i),
        .w_i        (axi_w_o),
        .b_valid_o  (axi_b_valid_i),
        .b_ready_i  (axi_b_ready_o),
        .b_o        (axi_b_i)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_beat(input refill_beat_t got, input refill_beat_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch refill_beat_o: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_ar(input axi_ar_t got, input axi_ar_t exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_wb_rsp(input wb_rsp_t got, input wb_rsp_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch wb_rsp_o: got %h expected %h", got, exp));
        end
    endtask

    // beat from the shadow memory with the error flag from bit 12
    function automatic refill_beat_t expected_beat(input logic [AXI_ADDR_W-1:0] addr,
                                                   input logic [BEAT_IDX_W-1:0] index);
        refill_beat_t beat;
        for (int i = 0; i < AXI_STRB_W; i++) begin
            beat.data[8*i +: 8] = shadow[{addr[12:5], index, 3'(i)}];
        end
        beat.idx  = index;
        beat.last = (index == 2'd3);
        beat.err  = addr[12];
        return beat;
    endfunction

    function automatic axi_ar_t expected_addr(input axi_ar_t got, input logic [31:0] line);
        axi_ar_t exp;
        exp       = got;  // cache and prot are not checked
        exp.id    = TXN_ID;
        exp.addr  = line;
        exp.len   = 8'd3;
        exp.size  = 3'd3;
        exp.burst = INCR;
        return exp;
    endfunction

    function automatic logic [AXI_ADDR_W-1:0] random_addr(input logic err, input logic odd);
        logic [AXI_ADDR_W-1:0] addr;
        addr                  = $urandom;
        addr[AXI_ADDR_W-1:13] = '0;
        addr[12]              = err;
        addr[5]               = odd;  // line parity keeps reads and writes apart
        return addr;
    endfunction

    function automatic line_data_t random_line_data();
        line_data_t data;
        for (int i = 0; i < LINE_BYTES / 4; i++) begin
            data[32*i +: 32] = $urandom;
        end
        return data;
    endfunction

    task automatic send_refill(input logic [AXI_ADDR_W-1:0] addr);
        while (!refill_ready_o) @(negedge clock);
        refill_valid_i    = 1'b1;
        refill_req_i.addr = addr;
        rd_addr_q.push_back({addr[AXI_ADDR_W-1:5], 5'b0});
        @(negedge clock);
        refill_valid_i = 1'b0;
    endtask

    task automatic send_wb(input logic [AXI_ADDR_W-1:0] addr, input line_data_t data,
                           input line_strb_t strb);
        logic [AXI_ADDR_W-1:0] line;
        line = {addr[AXI_ADDR_W-1:5], 5'b0};
        while (!wb_ready_o) @(negedge clock);
        wb_valid_i    = 1'b1;
        wb_req_i.addr = addr;
        wb_req_i.data = data;
        wb_req_i.strb = strb;
        wb_addr_q.push_back(line);
        for (int i = 0; i < LINE_BYTES; i++) begin
            if (strb[i] && !addr[12]) begin
                shadow[{line[12:5], 5'(i)}] = data[8*i +: 8];
            end
        end
        @(negedge clock);
        wb_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (rd_addr_q.size() != 0 || wb_addr_q.size() != 0) @(negedge clock);
    endtask

    // sampled mid-cycle where all registered outputs are settled
    always @(negedge clock) begin
        wb_rsp_t exp_rsp;
        if (reset) begin
            if (dcache_axi_bridge_i.props_i.fail_count != 0) begin
                report_failure("A bus protocol assertion failed");
            end
            if (axi_ar_valid_o && axi_ar_ready_i) begin
                if (rd_addr_q.size() == 0) begin
                    report_failure("AR request issued with no refill pending");
                end else begin
                    check_ar(axi_ar_o, expected_addr(axi_ar_o, rd_addr_q[0]), "axi_ar_o");
                end
            end
            if (axi_aw_valid_o && axi_aw_ready_i) begin
                if (wb_addr_q.size() == 0) begin
                    report_failure("AW request issued with no writeback pending");
                end else begin
                    check_ar(axi_aw_o, expected_addr(axi_aw_o, wb_addr_q[0]), "axi_aw_o");
                end
            end
            if (refill_beat_valid_o) begin
                if (rd_addr_q.size() == 0) begin
                    report_failure("Refill beat output with no refill pending");
                end else begin
                    check_beat(refill_beat_o, expected_beat(rd_addr_q[0], beat_idx));
                    if (beat_idx == 2'd3) begin
                        rd_addr_q.delete(0);
                    end
                    beat_idx = beat_idx + 1'b1;
                end
            end
            if (wb_done_o) begin
                if (wb_addr_q.size() == 0) begin
                    report_failure("Writeback done with no writeback pending");
                end else begin
                    exp_rsp.err = wb_addr_q[0][12];
                    check_wb_rsp(wb_rsp_o, exp_rsp);
                    wb_addr_q.delete(0);
                end
            end
        end
    end

    initial begin
        repeat (MAX_TXNS * CYCLES_PER_TXN) @(posedge clock);
        report_failure("Timeout, transactions did not complete in time");
    end

    initial begin
        logic [AXI_ADDR_W-1:0] addr;
        line_strb_t            strb;
        void'($urandom(32'h19d36f0a));
        reset          = 1'b0;
        refill_valid_i = 1'b0;
        refill_req_i   = '0;
        wb_valid_i     = 1'b0;
        wb_req_i       = '0;
        for (int a = 0; a < 8192; a++) begin
            shadow[a] = 8'(a * 7 + 3);
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        // control outputs of an idle bridge
        check_bit(axi_ar_valid_o, 1'b0, "axi_ar_valid_o");
        check_bit(axi_aw_valid_o, 1'b0, "axi_aw_valid_o");
        check_bit(axi_w_valid_o, 1'b0, "axi_w_valid_o");
        check_bit(axi_r_ready_o, 1'b0, "axi_r_ready_o");
        check_bit(axi_b_ready_o, 1'b0, "axi_b_ready_o");
        check_bit(refill_beat_valid_o, 1'b0, "refill_beat_valid_o");
        check_bit(wb_done_o, 1'b0, "wb_done_o");
        check_bit(refill_ready_o, 1'b1, "refill_ready_o");
        check_bit(wb_ready_o, 1'b1, "wb_ready_o");

        // plain refills alternating between the two regions
        for (int n = 0; n < 8; n++) begin
            send_refill(random_addr(1'(n), 1'($urandom)));
        end
        wait_idle();

        // beat 1 all clear and beat 2 all set with the last line in the error region
        for (int n = 0; n < 5; n++) begin
            addr         = random_addr(n == 4, 1'($urandom));
            strb         = $urandom;
            strb[15:8]   = 8'h00;
            strb[23:16]  = 8'hff;
            send_wb(addr, random_line_data(), strb);
            wait_idle();
            send_refill(addr);
            wait_idle();
        end

        fork
            send_refill(random_addr(1'b0, 1'b1));
            send_wb(random_addr(1'b1, 1'b0), random_line_data(), $urandom);
        join
        wait_idle();

        fork
            repeat (20) send_refill(random_addr(1'($urandom), 1'b1));
            repeat (20) send_wb(random_addr(1'($urandom), 1'b0), random_line_data(), $urandom);
        join
        wait_idle();
        repeat (5) @(negedge clock);

        if (dcache_axi_bridge_i.props_i.fail_count != 0) begin
            report_failure("A bus protocol assertion failed");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: dcache_axi_bridge.f
rtl/axi_pkg.sv
rtl/dcache_pkg.sv
rtl/dcache_line_reader.sv
rtl/dcache_line_writer.sv
rtl/dcache_axi_bridge.sv
tb/axi_slave_model.sv
tb/dcache_axi_bridge_properties.sv
tb/dcache_axi_bridge_tb.sv
